// File: hw/cdi_bus_pkg.sv
package cdi_bus_pkg;

    // CPU side widths
    typedef logic [23:1] bus_addr_t;   // Word address, A0 is implied by the data strobes
    typedef logic [23:0] bus_baddr_t;  // Byte address as seen on the map
    typedef logic [15:0] bus_word_t;
    typedef logic [7:0]  bus_byte_t;
    typedef logic [7:0]  bus_page_t;   // Bits 23..16 of a byte address

    // One CPU access as presented by the 68070 bus
    typedef struct packed {
        bus_addr_t addr;
        bus_word_t wdata;
        logic      as;
        logic      uds;
        logic      lds;
        logic      write_strobe;
    } bus_req_t;

    // Attached-device chip selects
    typedef struct packed {
        logic mcd212;
        logic cdic;
        logic slave;
        logic nvram;
    } chip_sel_t;

    // Response of one device towards the CPU
    typedef struct packed {
        bus_word_t data;
        logic      ack;
    } bus_resp_t;

    // NVRAM read handshake
    typedef enum logic {
        NV_IDLE = 1'b0,
        NV_ACK  = 1'b1
    } nvram_phase_t;

    // MCD212 owns the low 2.5 MB and everything from 4 MB up below bit 23
    localparam bus_baddr_t MCD212_TOP  = 24'h27FFFF;
    localparam bus_baddr_t MCD212_HIGH = 24'h400000;

    // 64 kB pages of the peripherals
    localparam bus_page_t CDIC_PAGE  = 8'h30;
    localparam bus_page_t SLAVE_PAGE = 8'h31;
    localparam bus_page_t NVRAM_PAGE = 8'h32;

    // RAM areas with nothing behind them
    localparam bus_baddr_t RAM_ERR1_LO = 24'h600000;
    localparam bus_baddr_t RAM_ERR1_HI = 24'hD00000;  // Exclusive
    localparam bus_baddr_t RAM_ERR2_LO = 24'hF00000;

endpackage

// File: hw/attex_decoder.sv
`timescale 1ns/1ns

module attex_decoder (
    input  cdi_bus_pkg::bus_req_t  req,
    output cdi_bus_pkg::chip_sel_t sel,
    output logic                   bus_err
);

    cdi_bus_pkg::bus_baddr_t baddr;
    cdi_bus_pkg::bus_page_t  page;

    logic in_mcd212;
    logic in_err1;
    logic in_err2;
    logic any_strobe;

    assign baddr = {req.addr, 1'b0};
    assign page  = baddr[23:16];

    // MCD212 window, bit 23 keeps the upper RAM areas out
    assign in_mcd212 = ((baddr <= cdi_bus_pkg::MCD212_TOP) ||
                        (baddr >= cdi_bus_pkg::MCD212_HIGH)) && !baddr[23];

    assign in_err1 = (baddr >= cdi_bus_pkg::RAM_ERR1_LO) &&
                     (baddr <  cdi_bus_pkg::RAM_ERR1_HI);
    assign in_err2 = baddr >= cdi_bus_pkg::RAM_ERR2_LO;

    assign any_strobe = req.uds || req.lds;

    always_comb begin
        sel.mcd212 = in_mcd212 && req.as;
        sel.cdic   = (page == cdi_bus_pkg::CDIC_PAGE) && req.as;
        sel.slave  = (page == cdi_bus_pkg::SLAVE_PAGE) && req.as;
        sel.nvram  = (page == cdi_bus_pkg::NVRAM_PAGE) && req.as;
    end

    // No error on an address-only cycle
    assign bus_err = (in_err1 || in_err2) && req.as && any_strobe;

endmodule

// File: hw/nvram_port.sv
`timescale 1ns/1ns

module nvram_port #(
    parameter int NVRAM_ADDR_W = 13
) (
    input  logic                  clk30,
    input  logic                  reset,
    input  cdi_bus_pkg::bus_req_t req,
    input  logic                  sel_nvram,
    output cdi_bus_pkg::bus_resp_t resp
);

    localparam int NVRAM_DEPTH = 1 << NVRAM_ADDR_W;

    cdi_bus_pkg::bus_byte_t     mem [NVRAM_DEPTH];
    cdi_bus_pkg::bus_byte_t     readout;
    cdi_bus_pkg::nvram_phase_t  phase;

    logic [NVRAM_ADDR_W-1:0] index;
    logic                    wr_access;
    logic                    rd_access;

    assign index     = req.addr[NVRAM_ADDR_W:1];
    assign wr_access = sel_nvram && req.write_strobe;
    assign rd_access = sel_nvram && !req.write_strobe;

    // Byte wide part on the upper lane only
    always_ff @(posedge clk30) begin
        if (wr_access && req.uds)
            mem[index] <= req.wdata[15:8];
        if (rd_access)
            readout <= mem[index];
    end

    // Read ack toggles while the CPU keeps the select asserted
    always_ff @(posedge clk30) begin
        if (reset) begin
            phase <= cdi_bus_pkg::NV_IDLE;
        end else if (!rd_access) begin
            phase <= cdi_bus_pkg::NV_IDLE;
        end else begin
            case (phase)
                cdi_bus_pkg::NV_IDLE: phase <= cdi_bus_pkg::NV_ACK;
                cdi_bus_pkg::NV_ACK:  phase <= cdi_bus_pkg::NV_IDLE;
                default:              phase <= cdi_bus_pkg::NV_IDLE;
            endcase
        end
    end

    // Writes complete in the select cycle
    assign resp.ack  = (phase == cdi_bus_pkg::NV_ACK) || wr_access;
    assign resp.data = {readout, readout};

endmodule

// File: hw/slave_port.sv
`timescale 1ns/1ns

module slave_port (
    input  logic                   clk30,
    input  logic                   reset,
    input  logic                   sel_slave,
    input  cdi_bus_pkg::bus_byte_t port_b_out,
    input  cdi_bus_pkg::bus_byte_t ddr_b,
    input  cdi_bus_pkg::bus_byte_t slave_porta,
    output cdi_bus_pkg::bus_resp_t resp,
    output logic                   slave_irq,
    output logic                   slave_rts,
    output logic                   in2
);

    // Port B pins of the slave microcontroller
    localparam int RTS_BIT   = 4;
    localparam int IN2_BIT   = 5;
    localparam int DTACK_BIT = 6;

    logic dtack_n;
    logic dtack_q;
    logic sel_q;

    // A pin configured as input floats high
    function automatic logic resolve_pin(
        input cdi_bus_pkg::bus_byte_t pin_out,
        input cdi_bus_pkg::bus_byte_t pin_dir,
        input int                     idx
    );
        logic level;
        level = pin_dir[idx] ? pin_out[idx] : 1'b1;
        return level;
    endfunction

    assign dtack_n   = resolve_pin(port_b_out, ddr_b, DTACK_BIT);
    assign slave_rts = resolve_pin(port_b_out, ddr_b, RTS_BIT);
    assign in2       = resolve_pin(port_b_out, ddr_b, IN2_BIT);

    always_ff @(posedge clk30) begin
        if (reset) begin
            dtack_q <= 1'b0;
            sel_q   <= 1'b0;
        end else begin
            dtack_q <= dtack_n;
            sel_q   <= sel_slave;
        end
    end

    // Wake the slave once per access
    assign slave_irq = sel_slave && !sel_q;

    // Slave firmware signals completion with a rising edge on the pin
    assign resp.ack  = dtack_n && !dtack_q;
    assign resp.data = {slave_porta, slave_porta};  // Mailbox byte on both lanes

endmodule

// File: hw/bus_response_mux.sv
`timescale 1ns/1ns

module bus_response_mux (
    input  cdi_bus_pkg::chip_sel_t sel,
    input  logic                   iack4,
    input  cdi_bus_pkg::bus_resp_t nv_resp,
    input  cdi_bus_pkg::bus_resp_t slave_resp,
    input  cdi_bus_pkg::bus_resp_t cdic_resp,
    input  cdi_bus_pkg::bus_resp_t mcd212_resp,
    output cdi_bus_pkg::bus_word_t data_in,
    output logic                   bus_ack
);

    cdi_bus_pkg::bus_resp_t chosen;

    // Unmapped accesses complete with zero data so the CPU never hangs
    always_comb begin
        chosen.data = '0;
        chosen.ack  = 1'b1;

        if (iack4) begin
            // CDIC supplies its own vector
            chosen.data = cdic_resp.data;
            chosen.ack  = 1'b1;
        end else if (sel.slave) begin
            chosen = slave_resp;
        end else if (sel.cdic) begin
            chosen = cdic_resp;
        end else if (sel.nvram) begin
            chosen = nv_resp;
        end else if (sel.mcd212) begin
            chosen = mcd212_resp;
        end
    end

    assign data_in = chosen.data;
    assign bus_ack = chosen.ack;

endmodule

// File: hw/cdi_bus_glue.sv
`timescale 1ns/1ns

module cdi_bus_glue #(
    parameter int NVRAM_ADDR_W = 13
) (
    input  logic                   clk30,
    input  logic                   reset,

    // 68070 bus
    input  cdi_bus_pkg::bus_addr_t addr,
    input  cdi_bus_pkg::bus_word_t cpu_data_out,
    input  logic                   as,
    input  logic                   uds,
    input  logic                   lds,
    input  logic                   write_strobe,
    input  logic                   iack4,

    // External video decoder and CD interface
    input  cdi_bus_pkg::bus_word_t cdic_dout,
    input  cdi_bus_pkg::bus_word_t mcd212_dout,
    input  logic                   cdic_ack,
    input  logic                   mcd212_ack,

    // Slave microcontroller pins
    input  cdi_bus_pkg::bus_byte_t port_b_out,
    input  cdi_bus_pkg::bus_byte_t ddr_b,
    input  cdi_bus_pkg::bus_byte_t slave_porta,

    output cdi_bus_pkg::bus_word_t data_in,
    output logic                   bus_ack,
    output logic                   bus_err,
    output logic                   cs_mcd212,
    output logic                   cs_cdic,
    output logic                   slave_irq,
    output logic                   slave_rts,
    output logic                   in2
);

    cdi_bus_pkg::bus_req_t  req;
    cdi_bus_pkg::chip_sel_t sel;
    cdi_bus_pkg::bus_resp_t nv_resp;
    cdi_bus_pkg::bus_resp_t slave_resp;
    cdi_bus_pkg::bus_resp_t cdic_resp;
    cdi_bus_pkg::bus_resp_t mcd212_resp;

    assign req = '{
        addr:         addr,
        wdata:        cpu_data_out,
        as:           as,
        uds:          uds,
        lds:          lds,
        write_strobe: write_strobe
    };

    assign cdic_resp   = '{data: cdic_dout, ack: cdic_ack};
    assign mcd212_resp = '{data: mcd212_dout, ack: mcd212_ack};

    attex_decoder decoder0 (
        .req,
        .sel,
        .bus_err
    );

    nvram_port #(
        .NVRAM_ADDR_W(NVRAM_ADDR_W)
    ) nvram0 (
        .clk30,
        .reset,
        .req,
        .sel_nvram(sel.nvram),
        .resp     (nv_resp)
    );

    slave_port slave0 (
        .clk30,
        .reset,
        .sel_slave(sel.slave),
        .port_b_out,
        .ddr_b,
        .slave_porta,
        .resp     (slave_resp),
        .slave_irq,
        .slave_rts,
        .in2
    );

    bus_response_mux mux0 (
        .sel,
        .iack4,
        .nv_resp,
        .slave_resp,
        .cdic_resp,
        .mcd212_resp,
        .data_in,
        .bus_ack
    );

    assign cs_mcd212 = sel.mcd212;  // To the external MCD212
    assign cs_cdic   = sel.cdic;

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk30,
    output logic reset
);

    initial begin
        clk30 = 1'b0;
        forever #2 clk30 = ~clk30;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk30);
        @(negedge clk30);
        reset = 1'b0;
    end

endmodule

// File: sim/cdi_bus_glue_checker.sv
`timescale 1ns/1ns

module cdi_bus_glue_checker (
    input logic                   clk30,
    input logic                   reset,
    input cdi_bus_pkg::chip_sel_t sel,
    input logic                   write_strobe,
    input logic                   iack4,
    input logic                   bus_ack,
    input logic                   bus_err,
    input logic                   slave_irq
);

    int unsigned fail_count = 0;
    logic        nv_read;

    assign nv_read = sel.nvram && !write_strobe && !iack4;  // IACK overrides the NVRAM response

    // Error areas lie far away from the peripheral pages
    err_vs_select: assert property (
        @(posedge clk30) disable iff (reset)
        bus_err |-> !(sel.nvram || sel.slave || sel.cdic)
    ) else begin
        fail_count++;
        $error("bus error raised together with a peripheral select");
    end

    irq_one_cycle: assert property (
        @(posedge clk30) disable iff (reset)
        slave_irq |=> !slave_irq
    ) else begin
        fail_count++;
        $error("slave interrupt held longer than one cycle");
    end

    nv_first_cycle: assert property (
        @(posedge clk30) disable iff (reset)
        $rose(nv_read) |-> !bus_ack
    ) else begin
        fail_count++;
        $error("acknowledge in the first NVRAM read cycle");
    end

endmodule

bind cdi_bus_glue cdi_bus_glue_checker chk0 (
    .clk30       (clk30),
    .reset       (reset),
    .sel         (sel),
    .write_strobe(write_strobe),
    .iack4       (iack4),
    .bus_ack     (bus_ack),
    .bus_err     (bus_err),
    .slave_irq   (slave_irq)
);

// File: sim/cdi_bus_glue_tb.sv
`timescale 1ns/1ns

module cdi_bus_glue_tb;

    localparam int NV_ADDR_W = 13;

    logic                   clk30;
    logic                   reset;
    cdi_bus_pkg::bus_addr_t addr;
    cdi_bus_pkg::bus_word_t cpu_data_out;
    logic                   as;
    logic                   uds;
    logic                   lds;
    logic                   write_strobe;
    logic                   iack4;
    cdi_bus_pkg::bus_word_t cdic_dout;
    cdi_bus_pkg::bus_word_t mcd212_dout;
    logic                   cdic_ack;
    logic                   mcd212_ack;
    cdi_bus_pkg::bus_byte_t port_b_out;
    cdi_bus_pkg::bus_byte_t ddr_b;
    cdi_bus_pkg::bus_byte_t slave_porta;
    cdi_bus_pkg::bus_word_t data_in;
    logic                   bus_ack;
    logic                   bus_err;
    logic                   cs_mcd212;
    logic                   cs_cdic;
    logic                   slave_irq;
    logic                   slave_rts;
    logic                   in2;

    logic [31:0] lcg_state = 32'h2d61_b192;

    tb_clock clock0 (
        .clk30,
        .reset
    );

    cdi_bus_glue #(
        .NVRAM_ADDR_W(NV_ADDR_W)
    ) dut0 (
        .clk30,
        .reset,
        .addr,
        .cpu_data_out,
        .as,
        .uds,
        .lds,
        .write_strobe,
        .iack4,
        .cdic_dout,
        .mcd212_dout,
        .cdic_ack,
        .mcd212_ack,
        .port_b_out,
        .ddr_b,
        .slave_porta,
        .data_in,
        .bus_ack,
        .bus_err,
        .cs_mcd212,
        .cs_cdic,
        .slave_irq,
        .slave_rts,
        .in2
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cdi_bus_pkg::bus_word_t got,
                              input cdi_bus_pkg::bus_word_t exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp));
    endtask

    task automatic bus_idle();
        addr         = '0;
        cpu_data_out = '0;
        as           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        iack4        = 1'b0;
    endtask

    // Word access on both lanes
    task automatic start_access(input cdi_bus_pkg::bus_baddr_t b, input logic wr);
        addr         = b[23:1];
        as           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        write_strobe = wr;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (reset !== 1'b0) begin
            if (n >= 32)
                fail_now("reset was never released");
            @(negedge clk30);
            n++;
        end
    endtask

    // Called right after driving on a falling edge, the current cycle counts as one
    task automatic wait_ack(input int limit, input string what);
        int n;
        n = 1;
        #1;
        while (bus_ack !== 1'b1) begin
            if (n >= limit)
                fail_now({"no acknowledge in time for ", what});
            @(negedge clk30);
            #1;
            n++;
        end
    endtask

    task automatic decode_random(input int count);
        logic [31:0]             r;
        logic [31:0]             s;
        cdi_bus_pkg::bus_baddr_t b;
        logic                    a_strobe;
        logic                    e_mcd;
        logic                    e_cdic;
        logic                    e_slave;
        logic                    e_nv;
        logic                    e_err;
        logic                    e_ack;
        logic                    data_known;
        cdi_bus_pkg::bus_word_t  e_data;
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            s = lcg_next();
            b = {r[31:9], 1'b0};
            if (r[2:0] == 3'd0) begin
                case (r[4:3])  // Steer some accesses onto the peripheral pages
                    2'd0:    b[23:16] = 8'h30;
                    2'd1:    b[23:16] = 8'h31;
                    2'd2:    b[23:16] = 8'h32;
                    default: b[23:16] = 8'h33;
                endcase
            end
            a_strobe = (r[7:5] != 3'd0);
            @(negedge clk30);
            start_access(b, 1'b0);
            as          = a_strobe;
            uds         = s[0];
            lds         = s[1];
            mcd212_dout = s[31:16];
            mcd212_ack  = s[2];
            cdic_dout   = s[23:8];
            cdic_ack    = s[3];
            slave_porta = s[15:8];
            e_mcd   = ((b <= 24'h27FFFF) || (b >= 24'h400000)) && !b[23] && a_strobe;
            e_cdic  = (b[23:16] == 8'h30) && a_strobe;
            e_slave = (b[23:16] == 8'h31) && a_strobe;
            e_nv    = (b[23:16] == 8'h32) && a_strobe;
            e_err   = (((b >= 24'h600000) && (b < 24'hD00000)) || (b >= 24'hF00000)) &&
                      a_strobe && (s[0] || s[1]);
            data_known = 1'b1;
            if (e_slave) begin
                e_data = {s[15:8], s[15:8]};
                e_ack  = 1'b0;  // DTACK pin is an input here and stays high
            end else if (e_cdic) begin
                e_data = s[23:8];
                e_ack  = s[3];
            end else if (e_nv) begin
                e_data     = '0;
                e_ack      = 1'b0;
                data_known = 1'b0;
            end else if (e_mcd) begin
                e_data = s[31:16];
                e_ack  = s[2];
            end else begin
                e_data = '0;
                e_ack  = 1'b1;
            end
            #1;
            check_bit("cs_mcd212", cs_mcd212, e_mcd);
            check_bit("cs_cdic", cs_cdic, e_cdic);
            check_bit("bus_err", bus_err, e_err);
            check_bit("bus_ack", bus_ack, e_ack);
            if (data_known)
                check_word("data_in", data_in, e_data);
            @(negedge clk30);
            bus_idle();
        end
    endtask

    task automatic port_b_resolve(input int count);
        logic [31:0] r;
        logic        e_rts;
        logic        e_in2;
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            @(negedge clk30);
            port_b_out = r[7:0];
            ddr_b      = r[15:8];
            e_rts = ddr_b[4] ? port_b_out[4] : 1'b1;
            e_in2 = ddr_b[5] ? port_b_out[5] : 1'b1;
            #1;
            check_bit("slave_rts", slave_rts, e_rts);
            check_bit("in2", in2, e_in2);
        end
    endtask

    task automatic slave_handshake(input int count);
        logic [31:0]            r;
        cdi_bus_pkg::bus_byte_t pa;
        int                     delay;
        @(negedge clk30);
        ddr_b      = 8'h40;  // Only DTACK driven, held low
        port_b_out = 8'h00;
        for (int i = 0; i < count; i++) begin
            r     = lcg_next();
            pa    = r[7:0];
            delay = 1 + int'(r[9:8]);
            @(negedge clk30);
            start_access({8'h31, r[30:16], 1'b0}, 1'b0);
            slave_porta = pa;
            #1;
            check_bit("slave_irq", slave_irq, 1'b1);
            check_bit("bus_ack", bus_ack, 1'b0);
            repeat (delay) begin
                @(negedge clk30);
                #1;
                check_bit("slave_irq", slave_irq, 1'b0);
                check_bit("bus_ack", bus_ack, 1'b0);
            end
            @(negedge clk30);
            port_b_out[6] = 1'b1;
            wait_ack(1, "slave DTACK");
            check_word("data_in", data_in, {pa, pa});
            @(negedge clk30);
            #1;
            check_bit("bus_ack", bus_ack, 1'b0);
            @(negedge clk30);
            bus_idle();
            port_b_out[6] = 1'b0;
        end
    endtask

    task automatic nvram_write_read(input int count);
        cdi_bus_pkg::bus_byte_t model [int];
        cdi_bus_pkg::bus_addr_t written [$];
        cdi_bus_pkg::bus_addr_t a;
        cdi_bus_pkg::bus_byte_t d;
        logic [31:0]            r;
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            a = {8'h32, r[15:1]};
            d = r[23:16];
            @(negedge clk30);
            start_access({a, 1'b0}, 1'b1);
            lds          = r[24];
            cpu_data_out = {d, ~d};
            wait_ack(1, "NVRAM write");
            model[int'(a[NV_ADDR_W:1])] = d;
            written.push_back(a);
            @(negedge clk30);
            bus_idle();
        end
        // Lower lane alone leaves the byte untouched
        a = written[0];
        d = ~model[int'(a[NV_ADDR_W:1])];
        @(negedge clk30);
        start_access({a, 1'b0}, 1'b1);
        uds          = 1'b0;
        cpu_data_out = {d, d};
        wait_ack(1, "NVRAM lower lane write");
        @(negedge clk30);
        bus_idle();
        foreach (written[i]) begin
            a = written[i];
            d = model[int'(a[NV_ADDR_W:1])];
            @(negedge clk30);
            start_access({a, 1'b0}, 1'b0);
            #1;
            check_bit("bus_ack", bus_ack, 1'b0);
            @(negedge clk30);
            wait_ack(1, "NVRAM read");
            check_word("data_in", data_in, {d, d});
            @(negedge clk30);
            bus_idle();
        end
    endtask

    task automatic response_priority(input int count);
        logic [31:0]             r;
        logic [31:0]             s;
        cdi_bus_pkg::bus_baddr_t b;
        cdi_bus_pkg::bus_baddr_t holes [2] = '{24'h28_0000, 24'h33_0000};
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            s = lcg_next();
            b = {r[31:9], 1'b0};
            if (r[1])
                b[23:16] = 8'h30 + {6'd0, r[3:2]};
            @(negedge clk30);
            start_access(b, 1'b0);
            iack4       = 1'b1;
            cdic_dout   = s[15:0];
            cdic_ack    = 1'b0;  // Vector cycle acks on its own
            mcd212_dout = s[31:16];
            mcd212_ack  = s[4];
            #1;
            check_word("data_in", data_in, s[15:0]);
            check_bit("bus_ack", bus_ack, 1'b1);
            @(negedge clk30);
            bus_idle();
        end
        for (int k = 0; k < 2; k++) begin
            s = lcg_next();
            @(negedge clk30);
            start_access(24'h30_0100, 1'b0);
            cdic_dout = s[15:0];
            cdic_ack  = k[0];
            #1;
            check_word("data_in", data_in, s[15:0]);
            check_bit("bus_ack", bus_ack, k[0]);
            @(negedge clk30);
            bus_idle();
            @(negedge clk30);
            start_access(24'h02_4680, 1'b0);
            mcd212_dout = s[31:16];
            mcd212_ack  = k[0];
            #1;
            check_word("data_in", data_in, s[31:16]);
            check_bit("bus_ack", bus_ack, k[0]);
            @(negedge clk30);
            bus_idle();
        end
        foreach (holes[i]) begin
            @(negedge clk30);
            start_access(holes[i], 1'b0);
            cdic_dout   = 16'hA5A5;
            mcd212_dout = 16'h5A5A;
            cdic_ack    = 1'b0;
            mcd212_ack  = 1'b0;
            #1;
            check_word("data_in", data_in, 16'h0000);
            check_bit("bus_ack", bus_ack, 1'b1);
            @(negedge clk30);
            bus_idle();
        end
    endtask

    // Stop at the first failed bus assertion
    always @(negedge clk30) begin
        if (dut0.chk0.fail_count != 0)
            fail_now("an assertion of the bus checker failed");
    end

    initial begin
        bus_idle();
        cdic_dout   = '0;
        mcd212_dout = '0;
        cdic_ack    = 1'b0;
        mcd212_ack  = 1'b0;
        port_b_out  = '0;
        ddr_b       = '0;
        slave_porta = '0;
        @(negedge clk30);
        wait_reset();

        decode_random(200);
        port_b_resolve(32);
        slave_handshake(4);
        nvram_write_read(12);
        response_priority(16);

        repeat (2) @(negedge clk30);
        if (dut0.chk0.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_now($sformatf("%0d assertion failures in the bus checker",
                               dut0.chk0.fail_count));
        end
    end

endmodule

// File: verilog.f
hw/cdi_bus_pkg.sv
hw/attex_decoder.sv
hw/nvram_port.sv
hw/slave_port.sv
hw/bus_response_mux.sv
hw/cdi_bus_glue.sv
sim/tb_clock.sv
sim/cdi_bus_glue_checker.sv
sim/cdi_bus_glue_tb.sv
